/* labrun_video_config.svh */
`ifndef LABRUN_VIDEO_CONFIG_SVH
`define LABRUN_VIDEO_CONFIG_SVH

// Horizontal raster, in pixels
`define H_TOTAL     384
`define H_ACTIVE    256
`define HS_START    288
`define HS_LEN      32

// Vertical raster, in lines
`define V_TOTAL     264
`define V_ACTIVE    224
`define VS_START    240
`define VS_LEN      8

// clk cycles per pixel
`define PXL_DIV     8

// Graphics ROM word address width
`define GFX_AW      18

`define PAL_ENTRIES 16

`endif

/* labrun_video_pkg.sv */
`default_nettype none

package labrun_video_pkg;

    // Palette index of one pixel
    typedef logic [3:0] pxl_code_t;

    // Beam position shared by all video blocks
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;    // line being fetched, one ahead of vdump
        logic       lhbl;
        logic       lvbl;
    } raster_pos_t;

    // CPU side sees two bytes, the mixer sees 5:5:5 colour
    typedef union packed {
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
        struct packed {
            logic       spare;
            logic [4:0] red;
            logic [4:0] green;
            logic [4:0] blue;
        } rgb;
    } pal_entry_u;

    // Pixel plus its blanking, moving through the mixer
    typedef struct packed {
        pxl_code_t code;
        logic      lhbl;
        logic      lvbl;
    } pxl_tag_t;

endpackage

`default_nettype wire

/* labrun_video_timing.sv */
`default_nettype none

`include "labrun_video_config.svh"

module labrun_video_timing (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic                           pxl_cen,
    output logic                           pxl2_cen,
    output labrun_video_pkg::raster_pos_t  pos,
    output logic                           HS,
    output logic                           VS
);
    import labrun_video_pkg::*;

    logic [$clog2(`PXL_DIV)-1:0] div;
    logic [8:0]                  hcnt;
    logic [8:0]                  vcnt;
    logic [8:0]                  vnext;

    // Clock enable divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    assign pxl_cen  = &div;
    assign pxl2_cen = &div[$clog2(`PXL_DIV)-2:0];

    // Beam counters advance once per pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == 9'(`H_TOTAL - 1)) begin
                hcnt <= '0;
                vcnt <= vnext;
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    // Next line, wrapping at the end of the frame
    assign vnext = (vcnt == 9'(`V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;

    assign pos = '{
        hdump:   hcnt,
        vdump:   vcnt,
        vrender: vnext,
        lhbl:    hcnt < 9'(`H_ACTIVE),
        lvbl:    vcnt < 9'(`V_ACTIVE)
    };

    // Active high sync levels
    assign HS = (hcnt >= 9'(`HS_START)) && (hcnt < 9'(`HS_START + `HS_LEN));
    assign VS = (vcnt >= 9'(`VS_START)) && (vcnt < 9'(`VS_START + `VS_LEN));

    // The beam never leaves the line
    a_hdump_range: assert property (@(posedge clk) disable iff (!rst_n)
        pos.hdump < 9'(`H_TOTAL));

endmodule

`default_nettype wire

/* labrun_tile_fetch.sv */
`default_nettype none

`include "labrun_video_config.svh"

module labrun_tile_fetch (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pxl_cen,
    input  labrun_video_pkg::raster_pos_t  pos,
    output logic [`GFX_AW-1:0]             gfx_addr,
    output logic                           gfx_romcs,
    input  logic [15:0]                    gfx_data,
    input  logic                           gfx_ok,
    output logic                           wr_en,
    output logic [7:0]                     wr_addr,
    output labrun_video_pkg::pxl_code_t    wr_code
);
    import labrun_video_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_REQ    = 2'd1;
    localparam logic [1:0] ST_UNPACK = 2'd2;

    logic [1:0]  state;
    logic [5:0]  col;
    logic [1:0]  nib;
    logic [8:0]  row;
    logic [15:0] word;
    logic        stale;
    logic        start;
    logic        line_end;

    // Fetch the next line once the visible part of this one is over
    assign start    = pxl_cen && (pos.hdump == 9'(`H_ACTIVE))
                      && (pos.vrender < 9'(`V_ACTIVE));
    assign line_end = pxl_cen && (pos.hdump == 9'(`H_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            col   <= '0;
            nib   <= '0;
            stale <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        col   <= '0;
                        nib   <= '0;
                        stale <= 1'b0;
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // A late word is still collected, then dropped
                    if (line_end) stale <= 1'b1;
                    if (gfx_ok) begin
                        nib   <= '0;
                        state <= (stale || line_end) ? ST_IDLE : ST_UNPACK;
                    end
                end
                ST_UNPACK: begin
                    nib <= nib + 2'd1;
                    if (line_end) begin
                        state <= ST_IDLE;
                    end else if (nib == 2'd3) begin
                        if (col == 6'd63) begin
                            state <= ST_IDLE;
                        end else begin
                            col   <= col + 6'd1;
                            state <= ST_REQ;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Row and ROM word
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) row <= pos.vrender;
        if (state == ST_REQ && gfx_ok) word <= gfx_data;
    end

    // One bitmap row of 64 words per line
    assign gfx_addr  = {{(`GFX_AW - 15){1'b0}}, row, col};
    assign gfx_romcs = (state == ST_REQ);

    // Lowest nibble is the leftmost pixel
    assign wr_en   = (state == ST_UNPACK);
    assign wr_addr = {col, nib};
    assign wr_code = word[{nib, 2'b00} +: 4];

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        gfx_romcs && !gfx_ok |=> gfx_romcs && $stable(gfx_addr));

endmodule

`default_nettype wire

/* labrun_line_buffer.sv */
`default_nettype none

module labrun_line_buffer (
    input  logic                         clk,
    input  logic                         wr_bank,
    input  logic                         wr_en,
    input  logic [7:0]                   wr_addr,
    input  labrun_video_pkg::pxl_code_t  wr_code,
    input  logic [7:0]                   rd_addr,
    output labrun_video_pkg::pxl_code_t  rd_code
);
    import labrun_video_pkg::*;

    // Two banks of one scanline each
    pxl_code_t mem [2][256];

    logic rd_bank;

    // The bank on screen is the one not being built
    assign rd_bank = ~wr_bank;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_code;
        end
    end

    // Registered read, one clk after the address
    always_ff @(posedge clk) begin
        rd_code <= mem[rd_bank][rd_addr];
    end

endmodule

`default_nettype wire

/* labrun_colmix.sv */
`default_nettype none

`include "labrun_video_config.svh"

module labrun_colmix (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pxl_cen,
    input  labrun_video_pkg::raster_pos_t  pos,
    input  labrun_video_pkg::pxl_code_t    rd_code,
    output logic [7:0]                     rd_addr,
    input  logic                           pal_cs,
    input  logic                           cpu_rnw,
    input  logic                           cpu_cen,
    input  logic [4:0]                     cpu_addr,
    input  logic [7:0]                     cpu_dout,
    output logic [7:0]                     pal_dout,
    output logic [4:0]                     red,
    output logic [4:0]                     green,
    output logic [4:0]                     blue,
    output logic                           LHBL_dly,
    output logic                           LVBL_dly
);
    import labrun_video_pkg::*;

    pal_entry_u pal [`PAL_ENTRIES];
    pal_entry_u pal_rd;
    pxl_tag_t   tag;
    logic [3:0] pal_idx;
    logic       pal_we;

    // Bit 0 picks the byte, bits 4..1 the entry
    assign pal_idx = cpu_addr[4:1];
    assign pal_we  = pal_cs && cpu_cen && !cpu_rnw;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            if (cpu_addr[0]) pal[pal_idx].bytes.hi <= cpu_dout;
            else pal[pal_idx].bytes.lo <= cpu_dout;
        end
    end

    // CPU readback
    always_ff @(posedge clk) begin
        pal_dout <= cpu_addr[0] ? pal[pal_idx].bytes.hi : pal[pal_idx].bytes.lo;
    end

    // Stage 1 takes the line buffer pixel with its blanking
    assign rd_addr = pos.hdump[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag <= '0;
        end else if (pxl_cen) begin
            tag.code <= rd_code;
            tag.lhbl <= pos.lhbl;
            tag.lvbl <= pos.lvbl;
        end
    end

    // Stage 2 is the palette lookup
    assign pal_rd = pal[tag.code];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (pxl_cen) begin
            LHBL_dly <= tag.lhbl;
            LVBL_dly <= tag.lvbl;
            if (tag.lhbl && tag.lvbl) begin
                red   <= pal_rd.rgb.red;
                green <= pal_rd.rgb.green;
                blue  <= pal_rd.rgb.blue;
            end else begin
                // Black during blanking
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

    // A palette strobe needs a defined read or write direction
    a_cpu_dir_known: assert property (@(posedge clk) disable iff (!rst_n)
        pal_cs && cpu_cen |-> !$isunknown(cpu_rnw));

endmodule

`default_nettype wire

/* labrun_video.sv */
`default_nettype none

`include "labrun_video_config.svh"

module labrun_video (
    input  logic                clk,
    input  logic                rst_n,
    output logic                pxl_cen,
    output logic                pxl2_cen,
    output logic                HS,
    output logic                VS,
    output logic                LHBL_dly,
    output logic                LVBL_dly,
    // CPU interface
    input  logic                pal_cs,
    input  logic                cpu_rnw,
    input  logic                cpu_cen,
    input  logic [4:0]          cpu_addr,
    input  logic [7:0]          cpu_dout,
    output logic [7:0]          pal_dout,
    // Graphics ROM
    output logic [`GFX_AW-1:0]  gfx_addr,
    output logic                gfx_romcs,
    input  logic [15:0]         gfx_data,
    input  logic                gfx_ok,
    // Colours
    output logic [4:0]          red,
    output logic [4:0]          green,
    output logic [4:0]          blue
);
    import labrun_video_pkg::*;

    raster_pos_t pos;
    pxl_code_t   wr_code;
    pxl_code_t   rd_code;
    logic [7:0]  wr_addr;
    logic [7:0]  rd_addr;
    logic        wr_en;
    logic        wr_bank;

    // Line parity picks the bank being built
    assign wr_bank = pos.vrender[0];

    labrun_video_timing u_timing (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .pos      ( pos      ),
        .HS       ( HS       ),
        .VS       ( VS       )
    );

    labrun_tile_fetch u_fetch (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .pos       ( pos       ),
        .gfx_addr  ( gfx_addr  ),
        .gfx_romcs ( gfx_romcs ),
        .gfx_data  ( gfx_data  ),
        .gfx_ok    ( gfx_ok    ),
        .wr_en     ( wr_en     ),
        .wr_addr   ( wr_addr   ),
        .wr_code   ( wr_code   )
    );

    labrun_line_buffer u_linebuf (
        .clk     ( clk     ),
        .wr_bank ( wr_bank ),
        .wr_en   ( wr_en   ),
        .wr_addr ( wr_addr ),
        .wr_code ( wr_code ),
        .rd_addr ( rd_addr ),
        .rd_code ( rd_code )
    );

    labrun_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos      ),
        .rd_code  ( rd_code  ),
        .rd_addr  ( rd_addr  ),
        .pal_cs   ( pal_cs   ),
        .cpu_rnw  ( cpu_rnw  ),
        .cpu_cen  ( cpu_cen  ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .pal_dout ( pal_dout ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

endmodule

`default_nettype wire

/* labrun_video_tb.sv */
`default_nettype none

`include "labrun_video_config.svh"

module labrun_video_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import labrun_video_pkg::*;

    localparam int WAIT_LIMIT = 1_000_000;

    logic              clk;
    logic              rst_n;
    logic              pal_cs;
    logic              cpu_rnw;
    logic              cpu_cen;
    logic [4:0]        cpu_addr;
    logic [7:0]        cpu_dout;
    logic [15:0]       gfx_data = '0;
    logic              gfx_ok = 1'b0;
    logic              pxl_cen;
    logic              pxl2_cen;
    logic              HS;
    logic              VS;
    logic              LHBL_dly;
    logic              LVBL_dly;
    logic [7:0]        pal_dout;
    logic [`GFX_AW-1:0] gfx_addr;
    logic              gfx_romcs;
    logic [4:0]        red, green, blue;

    // Scoreboard state written by the main process
    int checks = 0;
    int errors = 0;
    bit timed_out = 1'b0;

    // ROM model state
    bit                 req_seen = 1'b0;
    logic [`GFX_AW-1:0] addr_seen = '0;
    bit                 rom_busy = 1'b0;
    int                 rom_wait = 0;

    // Raster tracker state
    bit         pxl_due = 1'b0;
    bit         prev_lhbl = 1'b0;
    bit         prev_lvbl = 1'b0;
    bit         prev_vs = 1'b0;
    bit         prev_hs = 1'b0;
    int         vis_line = -1;
    int         col = 0;
    int         line_pix = 0;
    int         frame_lines = 0;
    int         last_lines = 0;
    int         vs_cnt = 0;
    int         last_vs = 0;
    int         vs_pix = 0;
    int         last_vs_pix = 0;
    int         hs_cnt = 0;
    int         last_hs = 0;
    int         hs_pix = 0;
    int         last_hs_pix = 0;
    int         frame_end_cnt = 0;
    int         bad_lines = 0;
    int         blank_nonzero = 0;
    pal_entry_u pix;
    pal_entry_u shot [`V_ACTIVE][`H_ACTIVE];

    // Enable rate tracker state
    int         cen_gap = 0;
    int         cen2_cnt = 0;
    bit         cen_seen = 1'b0;
    int         bad_cen = 0;

    // Pixel checks collected from the stimulus file
    int          p_line [$];
    int          p_col [$];
    logic [15:0] p_exp [$];

    labrun_video i_dut (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .pxl2_cen(pxl2_cen),
        .HS(HS), .VS(VS), .LHBL_dly(LHBL_dly), .LVBL_dly(LVBL_dly),
        .pal_cs(pal_cs), .cpu_rnw(cpu_rnw), .cpu_cen(cpu_cen),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .pal_dout(pal_dout),
        .gfx_addr(gfx_addr), .gfx_romcs(gfx_romcs), .gfx_data(gfx_data),
        .gfx_ok(gfx_ok), .red(red), .green(green), .blue(blue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ROM request seen half a cycle before the answering edge
    always @(negedge clk) begin
        req_seen  = gfx_romcs;
        addr_seen = gfx_addr;
    end

    // Graphics ROM with a random 1 to 8 clk latency
    always @(posedge clk) begin
        if (gfx_ok) begin
            gfx_ok <= 1'b0;
        end else if (req_seen) begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_wait = int'($urandom % 8);
            end
            if (rom_wait == 0) begin
                gfx_ok   <= 1'b1;
                gfx_data <= addr_seen[15:0] ^ 16'h5A3C;
                rom_busy = 1'b0;
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    // Pixel enable every PXL_DIV clk with two double-rate enables in between
    always @(negedge clk) begin
        if (rst_n) begin
            cen_gap++;
            if (pxl2_cen) cen2_cnt++;
            if (pxl_cen) begin
                if (cen_seen && (cen_gap != `PXL_DIV || cen2_cnt != 2)) bad_cen++;
                cen_seen = 1'b1;
                cen_gap  = 0;
                cen2_cnt = 0;
            end
        end
    end

    // Sample each output pixel once half a clk after it appears
    always @(negedge clk) begin
        if (rst_n && pxl_due) begin
            pix = {1'b0, red, green, blue};
            if ((!LHBL_dly || !LVBL_dly) && pix != '0) blank_nonzero++;
            if (VS && !prev_vs) vs_cnt++;
            if (HS && !prev_hs) hs_cnt++;
            if (VS) vs_pix++;
            if (HS) hs_pix++;
            if (LVBL_dly && !prev_lvbl) begin
                last_vs     = vs_cnt;
                last_vs_pix = vs_pix;
                last_hs     = hs_cnt;
                last_hs_pix = hs_pix;
                vs_cnt      = 0;
                vs_pix      = 0;
                hs_cnt      = 0;
                hs_pix      = 0;
                frame_lines = 0;
                vis_line    = -1;
            end
            if (!LVBL_dly && prev_lvbl) begin
                last_lines = frame_lines;
                frame_end_cnt++;
            end
            if (LHBL_dly && !prev_lhbl) begin
                col      = 0;
                line_pix = 0;
                if (LVBL_dly) begin
                    vis_line++;
                    frame_lines++;
                end
            end
            if (LHBL_dly) begin
                if (LVBL_dly && vis_line >= 0 && vis_line < `V_ACTIVE && col < `H_ACTIVE)
                    shot[vis_line][col] = pix;
                col++;
                line_pix++;
            end
            if (!LHBL_dly && prev_lhbl && line_pix != `H_ACTIVE) bad_lines++;
            prev_lhbl = LHBL_dly;
            prev_lvbl = LVBL_dly;
            prev_vs   = VS;
            prev_hs   = HS;
        end
        pxl_due = pxl_cen;
    end

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_rgb(input pal_entry_u got, input pal_entry_u exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0d ns: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic cpu_write(input logic [4:0] a, input logic [7:0] d);
        @(posedge clk);
        pal_cs   <= 1'b1;
        cpu_rnw  <= 1'b0;
        cpu_cen  <= 1'b1;
        cpu_addr <= a;
        cpu_dout <= d;
        @(posedge clk);
        pal_cs  <= 1'b0;
        cpu_rnw <= 1'b1;
        cpu_cen <= 1'b0;
    endtask

    task automatic cpu_read(input logic [4:0] a, output logic [7:0] d);
        @(posedge clk);
        pal_cs   <= 1'b1;
        cpu_rnw  <= 1'b1;
        cpu_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = pal_dout;
        @(posedge clk);
        pal_cs <= 1'b0;
    endtask

    task automatic wait_frame_end(input string what);
        int start;
        int n;
        start = frame_end_cnt;
        n = 0;
        while (frame_end_cnt == start && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (frame_end_cnt == start) begin
            $display("timeout: no end of frame seen while waiting for %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_frame(input string name);
        int e0;
        e0 = errors;
        for (int i = 0; i < p_line.size(); i++) begin
            check_rgb(shot[p_line[i]][p_col[i]], p_exp[i],
                      $sformatf("%s pixel line %0d col %0d", name, p_line[i], p_col[i]));
        end
        check_count(last_lines, `V_ACTIVE, "visible lines in frame");
        check_count(last_vs, 1, "VS pulses in frame");
        check_count(last_vs_pix, `VS_LEN * `H_TOTAL, "VS high pixels in frame");
        check_count(last_hs, `V_TOTAL, "HS pulses in frame");
        check_count(last_hs_pix, `V_TOTAL * `HS_LEN, "HS high pixels in frame");
        check_count(bad_lines, 0, "lines with wrong active pixel count");
        check_count(blank_nonzero, 0, "non-black pixels in blanking");
        check_count(bad_cen, 0, "pixel enables with wrong spacing");
        $display("test %s: %0d errors", name, errors - e0);
    endtask

    task automatic run_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a, b, c;
        logic [7:0]  rd;
        fd = $fopen("labrun_video_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file labrun_video_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 2 && line.getc(0) != "#") begin
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c);
                if (line.getc(0) == "W") begin
                    cpu_write(a[4:0], b[7:0]);
                end else if (line.getc(0) == "R") begin
                    cpu_read(a[4:0], rd);
                    check_byte(rd, b[7:0], $sformatf("palette byte %0d readback", a));
                end else if (line.getc(0) == "P") begin
                    p_line.push_back(int'(a));
                    p_col.push_back(int'(b));
                    p_exp.push_back(c[15:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int n;
        int e0;
        void'($urandom(32'h6627));
        rst_n    = 1'b0;
        pal_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet outputs until the first visible pixel
        e0 = errors;
        n = 0;
        @(negedge clk);
        while (!(LHBL_dly && LVBL_dly) && n < WAIT_LIMIT) begin
            check_count(int'(gfx_romcs), 0, "gfx_romcs before first active line");
            check_count(int'(HS), 0, "HS before first active line");
            check_count(int'(VS), 0, "VS before first active line");
            check_rgb({1'b0, red, green, blue}, '0, "colour before first active line");
            @(negedge clk);
            n++;
        end
        if (!(LHBL_dly && LVBL_dly)) begin
            $display("timeout: the first active line never started");
            timed_out = 1'b1;
        end
        $display("test reset_idle: %0d errors", errors - e0);

        if (!timed_out) begin
            e0 = errors;
            run_stimulus();
            $display("test palette_rw: %0d errors", errors - e0);
            // The frame in progress saw the palette change, so skip it
            wait_frame_end("the first frame");
        end
        if (!timed_out) wait_frame_end("pixel frame 1");
        if (!timed_out) check_frame("pixels_frame1");
        if (!timed_out) wait_frame_end("pixel frame 2");
        if (!timed_out) check_frame("pixels_frame2");

        $display("checks %0d errors %0d timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* labrun_video_stimulus.txt */
# W addr data | R addr expected_byte | P line column expected_rgb
# All fields hex, palette byte address is entry*2 plus 1 for the high byte
W 18 00
W 19 7c
W 0e e0
W 0f 03
W 0a 1f
W 0b 00
W 0c 95
W 0d d2
R 19 7c
R 0d d2
R 0e e0
P 01 00 7c00
P 01 01 03e0
P 02 00 7c00
P 02 03 001f
P df ff 5295

/* verilog.f */
+incdir+.
labrun_video_pkg.sv
labrun_video_timing.sv
labrun_tile_fetch.sv
labrun_line_buffer.sv
labrun_colmix.sv
labrun_video.sv
labrun_video_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module labrun_video_tb \
    -o labrun_video_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/labrun_video_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
